// File: src.f
+incdir+design
design/mac_data_pkg.sv
design/mac_op_pkg.sv
design/csa42.sv
design/pp_gen.sv
design/compress_tree.sv
design/cs_accum.sv
design/cpa_resolve.sv
design/mac_top.sv
verif/mac_clk_gen.sv
verif/mac_tb.sv

// File: Makefile
# Verilator build and run of the MAC testbench

SRCS := $(filter-out +%,$(shell cat src.f))

all: run

# rebuilt only when a source, the header or the file list changes
obj_dir/Vmac_tb: src.f $(SRCS) design/mac_consts.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module mac_tb -Mdir obj_dir -o Vmac_tb

run: obj_dir/Vmac_tb
	@out="$$(./obj_dir/Vmac_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: verif/mac_tb.sv
// Expects a result for every strobe in strobe order and exactly four edges after it
`timescale 1ns/1ps
`include "mac_consts.svh"

module mac_tb
   import mac_data_pkg::*;
   import mac_op_pkg::*;
();

   localparam int DRIVE_DLY   = 1;        // ns after the rising edge
   localparam int WAIT_LIMIT  = 60;       // cycles allowed per wait
   localparam int LATENCY     = 4;        // strobe edge to result edge

   logic clk, rst_n, in_valid, result_valid;
   operand_t a, b;
   mac_op_e  op;
   acc_t     result;

   // stimulus table, one column per queue
   string    tbl_name[$];
   mac_op_e  tbl_op[$];
   operand_t tbl_a[$];
   operand_t tbl_b[$];
   int       tbl_gap[$];                  // idle cycles after the entry
   acc_t     tbl_exp[$];

   acc_t        model_acc = '0;           // reference accumulator
   logic [31:0] lfsr = 32'h1978_e890;
   int          error_cnt = 0;
   int          pass_cnt = 0;
   bit          timed_out = 1'b0;

   mac_clk_gen i_mac_clk_gen (.clk(clk), .rst_n(rst_n));

   mac_top i_mac_top (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .op(op),
      .result(result), .result_valid(result_valid)
   );

   //#########################################################################
   // table building and reference model
   //#########################################################################
   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic add_entry(input string name, input mac_op_e e_op,
                            input operand_t e_a, input operand_t e_b, input int gap);
      case (e_op)
         op_mul:  model_acc = acc_t'(e_a) * acc_t'(e_b);
         op_mac:  model_acc = model_acc + acc_t'(e_a) * acc_t'(e_b);   // wraps at 2^24
         default: model_acc = '0;
      endcase
      tbl_name.push_back(name);
      tbl_op.push_back(e_op);
      tbl_a.push_back(e_a);
      tbl_b.push_back(e_b);
      tbl_gap.push_back(gap);
      tbl_exp.push_back(model_acc);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
         error_cnt++;
      end
   endtask

   //#########################################################################
   // driver and collector
   //#########################################################################
   task automatic wait_reset_release();
      int n;
      n = 0;
      while (!rst_n && !timed_out) begin
         @(posedge clk);
         n++;
         if (n > WAIT_LIMIT) begin
            $display("reset never released");
            timed_out = 1'b1;
            error_cnt++;
         end
      end
   endtask

   task automatic drive_all();
      wait_reset_release();
      repeat (5) @(posedge clk);          // idle so a stray result would show
      #DRIVE_DLY;
      for (int i = 0; i < tbl_name.size() && !timed_out; i++) begin
         in_valid = 1'b1;
         op = tbl_op[i];
         a  = tbl_a[i];
         b  = tbl_b[i];
         for (int g = 0; g < tbl_gap[i]; g++) begin
            @(posedge clk);
            #DRIVE_DLY in_valid = 1'b0;
         end
         @(posedge clk);
         #DRIVE_DLY;
      end
      in_valid = 1'b0;
   endtask

   // outputs sampled on the falling edge, half a cycle away from any update
   task automatic collect_results();
      int got, wait_cnt, edge_idx, err_before;
      int strobe_edge[$];
      got = 0;
      wait_cnt = 0;
      edge_idx = 0;
      wait_reset_release();
      while (got < tbl_name.size() && !timed_out) begin
         @(negedge clk);
         edge_idx++;
         if (in_valid) strobe_edge.push_back(edge_idx);
         if (result_valid && strobe_edge.size() == 0) begin
            $display("result_valid pulsed with no strobe waiting for it");
            error_cnt++;
         end else if (result_valid) begin
            err_before = error_cnt;
            check_value($sformatf("%s latency", tbl_name[got]), LATENCY,
                        32'(edge_idx - strobe_edge.pop_front()));
            check_value(tbl_name[got], 32'(tbl_exp[got]), 32'(result));
            if (error_cnt == err_before) pass_cnt++;
            $display("test %s: %s, result 0x%06h", tbl_name[got],
                     (error_cnt == err_before) ? "ok" : "bad", result);
            got++;
            wait_cnt = 0;
         end else begin
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
               $display("no result for test %s within %0d cycles", tbl_name[got],
                        WAIT_LIMIT);
               timed_out = 1'b1;
               error_cnt++;
            end
         end
      end
   endtask

   //#########################################################################
   // main sequence
   //#########################################################################
   initial begin
      logic [1:0] r_op;
      in_valid = 1'b0;
      a  = '0;
      b  = '0;
      op = op_mul;
      // corner products
      add_entry("mul_zero",   op_mul, 8'd0,   8'd200, 0);
      add_entry("mul_one",    op_mul, 8'd1,   8'd1,   0);
      add_entry("mul_one_ff", op_mul, 8'd1,   8'd255, 1);
      add_entry("mul_ff_ff",  op_mul, 8'd255, 8'd255, 0);
      add_entry("mul_bit7",   op_mul, 8'd128, 8'd1,   2);
      add_entry("mul_bits",   op_mul, 8'd16,  8'd32,  0);
      add_entry("mul_ff_80",  op_mul, 8'd255, 8'd128, 3);
      // accumulate chain, back to back then spread out
      add_entry("chain_load", op_mul, 8'd3,   8'd5,   0);
      add_entry("chain_b2b1", op_mac, 8'd7,   8'd9,   0);
      add_entry("chain_b2b2", op_mac, 8'd200, 8'd100, 0);
      add_entry("chain_b2b3", op_mac, 8'd255, 8'd1,   0);
      add_entry("chain_gap1", op_mac, 8'd17,  8'd19,  3);
      add_entry("chain_gap2", op_mac, 8'd12,  8'd34,  1);
      add_entry("chain_gap3", op_mac, 8'd99,  8'd99,  5);
      // clear then a fresh sum
      add_entry("clr_b2b",    op_clr, 8'd77,  8'd88,  0);
      add_entry("clr_mac",    op_mac, 8'd6,   8'd7,   0);
      add_entry("clr_gap",    op_clr, 8'd0,   8'd0,   2);
      add_entry("clr_mac_ff", op_mac, 8'd255, 8'd255, 1);
      // 260 x 65025 passes 2^24
      add_entry("wrap_clr",   op_clr, 8'd0,   8'd0,   0);
      for (int i = 0; i < 260; i++) begin
         add_entry($sformatf("wrap_%0d", i), op_mac, 8'd255, 8'd255, 0);
      end
      for (int i = 0; i < 40; i++) begin
         r_op = 2'(take_bits(2));
         add_entry($sformatf("rand_%0d", i), (r_op == 2'b11) ? op_mac : mac_op_e'(r_op),
                   operand_t'(take_bits(`MAC_OP_W)), operand_t'(take_bits(`MAC_OP_W)),
                   int'(take_bits(1)));
      end

      fork
         drive_all();
         collect_results();
      join

      $display("tests %0d, passed %0d, failed %0d, errors %0d", tbl_name.size(),
               pass_cnt, tbl_name.size() - pass_cnt, error_cnt);
      if (error_cnt == 0 && !timed_out && pass_cnt == tbl_name.size()) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verif/mac_clk_gen.sv
// Free running clock with an even period and a reset released just after an edge
`timescale 1ns/1ps

module mac_clk_gen #(
   parameter int PERIOD     = 8,          // ns
   parameter int RST_CYCLES = 2           // edges with rst_n low
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;                       // asserted from time zero
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;                    // off the edge, like the stimulus
   end

endmodule

// File: design/mac_top.sv
// No back-pressure so every strobe gives one result four edges later and sums wrap at 2^24
`timescale 1ns/1ps

module mac_top
   import mac_data_pkg::*;
   import mac_op_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,             // one cycle strobe
   input  operand_t a,
   input  operand_t b,
   input  mac_op_e  op,
   output acc_t     result,
   output logic     result_valid          // one cycle pulse
);

   //##########################################################################
   // stage nets
   //##########################################################################
   logic     pp_valid;                    // producer front end
   mac_op_e  pp_op;
   pp_rows_t rows;
   logic     prod_valid;                  // after reduction, same cycle
   mac_op_e  prod_op;
   acc_t     prod_s;
   acc_t     prod_c;
   logic     acc_valid;                   // buffer
   acc_t     acc_s;
   acc_t     acc_c;

   //##########################################################################
   // producer
   //##########################################################################
   pp_gen i_pp_gen (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .a          (a),
      .b          (b),
      .op         (op),
      .pp_valid   (pp_valid),
      .pp_op      (pp_op),
      .rows       (rows)
   );

   compress_tree i_compress_tree (
      .rows       (rows),
      .pp_valid   (pp_valid),
      .pp_op      (pp_op),
      .prod_s     (prod_s),
      .prod_c     (prod_c),
      .prod_valid (prod_valid),
      .prod_op    (prod_op)
   );

   // buffer then consumer
   cs_accum i_cs_accum (
      .clk        (clk),
      .rst_n      (rst_n),
      .prod_valid (prod_valid),
      .prod_op    (prod_op),
      .prod_s     (prod_s),
      .prod_c     (prod_c),
      .acc_valid  (acc_valid),
      .acc_s      (acc_s),
      .acc_c      (acc_c)
   );

   cpa_resolve i_cpa_resolve (
      .clk          (clk),
      .rst_n        (rst_n),
      .acc_valid    (acc_valid),
      .acc_s        (acc_s),
      .acc_c        (acc_c),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

// File: design/cpa_resolve.sv
// Two cycle latency from acc_valid with the top carry of the high half dropped for the wrap
`timescale 1ns/1ps
`include "mac_consts.svh"

module cpa_resolve
   import mac_data_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic acc_valid,                // new accumulator state
   input  acc_t acc_s,
   input  acc_t acc_c,                    // weight one
   output acc_t result,                   // binary accumulator
   output logic result_valid              // two cycles after acc_valid
);

   //##########################################################################
   // stage one, low half
   //##########################################################################
   logic [`MAC_HALF_W:0]   lo_add;        // low sum with carry out on top
   logic [`MAC_HALF_W-1:0] lo_q;          // registered low result
   logic                   co_q;          // carry into the high half
   logic [`MAC_HALF_W-1:0] hi_s_q;        // high half of sum, delayed
   logic [`MAC_HALF_W-1:0] hi_c_q;        // high half of carry, delayed
   logic                   v1_q;          // stage one valid

   assign lo_add = {1'b0, acc_s[`MAC_HALF_W-1:0]} + {1'b0, acc_c[`MAC_HALF_W-1:0]};

   //##########################################################################
   // stage two, high half
   //##########################################################################
   logic [`MAC_HALF_W-1:0] hi_add;        // high result, carry out lost

   assign hi_add = hi_s_q + hi_c_q + {{(`MAC_HALF_W-1){1'b0}}, co_q};

   // valid pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         v1_q         <= 1'b0;
         result_valid <= 1'b0;
      end else begin
         v1_q         <= acc_valid;
         result_valid <= v1_q;
      end
   end

   // payload pipeline
   always_ff @(posedge clk) begin
      if (acc_valid) begin
         lo_q   <= lo_add[`MAC_HALF_W-1:0];
         co_q   <= lo_add[`MAC_HALF_W];
         hi_s_q <= acc_s[`MAC_ACC_W-1:`MAC_HALF_W];
         hi_c_q <= acc_c[`MAC_ACC_W-1:`MAC_HALF_W];
      end
      if (v1_q) begin
         result <= {hi_add, lo_q};       // low half rides along one more cycle
      end
   end

   // split adder must match one full width add of the state two edges back
   a_result_sum : assert property (@(posedge clk) disable iff (!rst_n)
      result_valid |-> result == $past(acc_t'(acc_s + acc_c), 2))
      else $error("result differs from sum plus carry of its accumulator state");

endmodule

// File: design/cs_accum.sv
// Accumulator stays in carry-save form and an illegal op code leaves it unchanged
`timescale 1ns/1ps
`include "mac_consts.svh"

module cs_accum
   import mac_data_pkg::*;
   import mac_op_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     prod_valid,           // new product this cycle
   input  mac_op_e  prod_op,
   input  acc_t     prod_s,
   input  acc_t     prod_c,               // weight one
   output logic     acc_valid,            // one pulse per operation
   output acc_t     acc_s,                // accumulator sum
   output acc_t     acc_c                 // accumulator carry, weight one
);

   //##########################################################################
   // merge row
   //##########################################################################
   acc_t mrg_s;                           // product plus accumulator, sum
   acc_t mrg_c;                           // product plus accumulator, carry

   // the intra-stage chain matters here since all four inputs are dense
   csa42 #(.N(`MAC_ACC_W)) i_csa_acc (
      .in0  (prod_s),
      .in1  (prod_c),
      .in2  (acc_s),
      .in3  (acc_c),
      .cin  (1'b0),
      .cout (),                           // modulo 2^24
      .s    (mrg_s),
      .c    (mrg_c)
   );

   //##########################################################################
   // accumulator state
   //##########################################################################
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_valid <= 1'b0;
         acc_s     <= '0;
         acc_c     <= '0;
      end else begin
         acc_valid <= prod_valid;         // clear pulses too
         if (prod_valid) begin
            case (prod_op)
               op_mul: begin              // load
                  acc_s <= prod_s;
                  acc_c <= prod_c;
               end
               op_mac: begin              // accumulate
                  acc_s <= mrg_s;
                  acc_c <= {mrg_c[`MAC_ACC_W-2:0], 1'b0};
               end
               op_clr: begin
                  acc_s <= '0;
                  acc_c <= '0;
               end
               default: ;                 // 2'b11 holds
            endcase
         end
      end
   end

   // an accumulate adds the product to the represented value, wrapping at 2^24
   a_mac_sum : assert property (@(posedge clk) disable iff (!rst_n)
      (prod_valid && prod_op == op_mac) |=>
         acc_t'(acc_s + acc_c) == $past(acc_t'(acc_s + acc_c + prod_s + prod_c)))
      else $error("accumulate lost the sum of product and accumulator");

endmodule

// File: design/compress_tree.sv
// Purely combinational and the dropped top carries give the modulo 2^24 wrap of the product
`timescale 1ns/1ps
`include "mac_consts.svh"

module compress_tree
   import mac_data_pkg::*;
   import mac_op_pkg::*;
(
   input  pp_rows_t rows,                 // eight weighted rows
   input  logic     pp_valid,
   input  mac_op_e  pp_op,
   output acc_t     prod_s,               // product sum vector
   output acc_t     prod_c,               // product carry already at weight one
   output logic     prod_valid,           // aligned copy of pp_valid
   output mac_op_e  prod_op
);

   //##########################################################################
   // first level
   //##########################################################################
   acc_t lo_s;                            // rows 0..3 sum
   acc_t lo_c;                            // rows 0..3 carry, weight two
   acc_t hi_s;                            // rows 4..7 sum
   acc_t hi_c;                            // rows 4..7 carry, weight two
   acc_t fin_c;                           // last level carry, weight two

   csa42 #(.N(`MAC_ACC_W)) i_csa_lo (
      .in0  (rows[0]),
      .in1  (rows[1]),
      .in2  (rows[2]),
      .in3  (rows[3]),
      .cin  (1'b0),
      .cout (),                           // weight 2^24 falls off
      .s    (lo_s),
      .c    (lo_c)
   );

   csa42 #(.N(`MAC_ACC_W)) i_csa_hi (
      .in0  (rows[4]),
      .in1  (rows[5]),
      .in2  (rows[6]),
      .in3  (rows[7]),
      .cin  (1'b0),
      .cout (),
      .s    (hi_s),
      .c    (hi_c)
   );

   //##########################################################################
   // second level
   //##########################################################################
   // carries move up one place to their real weight before merging
   csa42 #(.N(`MAC_ACC_W)) i_csa_fin (
      .in0  (lo_s),
      .in1  ({lo_c[`MAC_ACC_W-2:0], 1'b0}),
      .in2  (hi_s),
      .in3  ({hi_c[`MAC_ACC_W-2:0], 1'b0}),
      .cin  (1'b0),
      .cout (),
      .s    (prod_s),
      .c    (fin_c)
   );

   assign prod_c     = {fin_c[`MAC_ACC_W-2:0], 1'b0};   // top bit wraps away
   assign prod_valid = pp_valid;          // no register in this stage
   assign prod_op    = pp_op;

endmodule

// File: design/pp_gen.sv
// Unsigned operands only and rows keep the last captured operands while pp_valid is low
`timescale 1ns/1ps
`include "mac_consts.svh"

module pp_gen
   import mac_data_pkg::*;
   import mac_op_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,             // one cycle strobe
   input  operand_t a,                    // multiplicand
   input  operand_t b,                    // multiplier
   input  mac_op_e  op,
   output logic     pp_valid,             // high the cycle after the strobe
   output mac_op_e  pp_op,                // captured op
   output pp_rows_t rows                  // weighted partial products
);

   //##########################################################################
   // operand capture
   //##########################################################################
   operand_t a_q;                         // registered multiplicand
   operand_t b_q;                         // registered multiplier

   // strobe pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pp_valid <= 1'b0;
      end else begin
         pp_valid <= in_valid;
      end
   end

   // payload only moves on a strobe
   always_ff @(posedge clk) begin
      if (in_valid) begin
         a_q   <= a;
         b_q   <= b;
         pp_op <= op;
      end
   end

   //##########################################################################
   // partial product rows
   //##########################################################################
   // row k is a_q gated by b_q[k] and moved up k places,
   // it fits in the product width and is zero extended above that
   always_comb begin
      for (int k = 0; k < `MAC_PP_ROWS; k++) begin
         rows[k] = acc_t'(prod_t'(a_q & {`MAC_OP_W{b_q[k]}}) << k);
      end
   end

   // illegal code would silently leave the accumulator untouched downstream
   a_legal_op : assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> op inside {op_mul, op_mac, op_clr})
      else $error("illegal op code with in_valid");

endmodule

// File: design/csa42.sv
// Unsigned bit vectors only and each bit is two plain full adders with cout weighing 2^N
`timescale 1ns/1ps

module csa42 #(
   parameter int N = 8                   // row width
) (
   input  logic [N-1:0] in0,
   input  logic [N-1:0] in1,
   input  logic [N-1:0] in2,
   input  logic [N-1:0] in3,
   input  logic         cin,             // enters the chain at bit 0
   output logic         cout,            // top carry of the first row
   output logic [N-1:0] s,               // sum
   output logic [N-1:0] c                // carry with weight two
);

   //##########################################################################
   // internal nets
   //##########################################################################
   logic [N-1:0] sum_int;                // first row sums
   logic [N:0]   carry_int;              // first row carries shifted up by one

   // chain ends
   assign carry_int[0] = cin;
   assign cout         = carry_int[N];

   //##########################################################################
   // two rows of full adders
   //##########################################################################
   // the first row carries go one position up into the second row,
   // so s + 2c + 2^N cout equals in0 + in1 + in2 + in3 + cin
   // no ripple here since carry_int[i+1] only sees first row inputs
   for (genvar i = 0; i < N; i++) begin : g_bit
      // row one adds in0, in1 and in2
      assign sum_int[i]     = in0[i] ^ in1[i] ^ in2[i];
      assign carry_int[i+1] = (in0[i] & in1[i]) |
                              (in0[i] & in2[i]) |
                              (in1[i] & in2[i]);

      // row two adds in3, the local sum and the carry from one bit down
      assign s[i] = in3[i] ^ sum_int[i] ^ carry_int[i];
      assign c[i] = (in3[i] & sum_int[i])     |
                    (in3[i] & carry_int[i])   |
                    (sum_int[i] & carry_int[i]);
   end

endmodule

// File: design/mac_op_pkg.sv
// Three legal operation codes and 2'b11 must never be sent with a strobe
package mac_op_pkg;

   //##########################################################################
   // operation codes
   //##########################################################################
   typedef enum logic [1:0] {
      op_mul = 2'b00,   // load a times b
      op_mac = 2'b01,   // add a times b to the accumulator
      op_clr = 2'b10    // zero the accumulator
      // 2'b11 has no meaning
   } mac_op_e;

endpackage

// File: design/mac_data_pkg.sv
// Vector types only and all of them are unsigned with widths taken from mac_consts.svh
`include "mac_consts.svh"

package mac_data_pkg;

   //##########################################################################
   // operand and product vectors
   //##########################################################################
   typedef logic [`MAC_OP_W-1:0]   operand_t;   // one input operand
   typedef logic [`MAC_PROD_W-1:0] prod_t;      // a times b before extension

   //##########################################################################
   // accumulator width vectors
   //##########################################################################
   // sum and carry vectors, the accumulator and the result all share this width
   typedef logic [`MAC_ACC_W-1:0]  acc_t;

   // eight rows, each already shifted to its weight
   typedef acc_t [`MAC_PP_ROWS-1:0] pp_rows_t;

endpackage

// File: design/mac_consts.svh
// Sizes fixed for an unsigned 8x8 MAC and the 24-bit accumulator wraps modulo 2^24
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

//##########################################################################
// datapath widths
//##########################################################################
`define MAC_OP_W     8    // operand width
`define MAC_PP_ROWS  8    // one partial product per multiplier bit
`define MAC_PROD_W   16   // full unsigned product
`define MAC_ACC_W    24   // accumulator and result
`define MAC_HALF_W   12   // one carry-propagate stage, half of the accumulator

`endif
